// ==== source/ctl_bus_pkg.sv ====
package ctl_bus_pkg;

    localparam int WORD_W = 16;
    localparam int ADDR_W = 8;

    localparam logic [ADDR_W-1:0] ADDR_CTL_FLAG      = 8'h00;
    localparam logic [ADDR_W-1:0] ADDR_FPGA_STATE    = 8'h01;
    localparam logic [ADDR_W-1:0] ADDR_VERSION_MAJOR = 8'h02;
    localparam logic [ADDR_W-1:0] ADDR_VERSION_MINOR = 8'h03;

    localparam logic [ADDR_W-1:0] SILENCER_BASE_ADDR = 8'h50; // Five consecutive words
    localparam logic [ADDR_W-1:0] SYNC_BASE_ADDR     = 8'h60; // Four consecutive words

    localparam int unsigned CTL_FLAG_SILENCER_SET = 2;
    localparam int unsigned CTL_FLAG_SYNC_SET     = 5;
    localparam int unsigned CTL_FLAG_FORCE_FAN    = 13;

    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
    } ctl_req_t;

    // Harmless filler for cycles without a real request
    localparam ctl_req_t CTL_REQ_IDLE = '{
        we:    1'b0,
        addr:  ADDR_CTL_FLAG,
        wdata: '0
    };

    typedef enum logic [1:0] {
        TAG_CTL_FLAG,
        TAG_SILENCER,
        TAG_SYNC
    } read_tag_t;

    typedef struct packed {
        logic       valid;
        read_tag_t  tag;
        logic [2:0] idx;    // Word index inside the settings group
    } read_return_t;

    typedef struct packed {
        logic [11:0] reserved;
        logic        stm_cycle_zero;
        logic        stm_segment;
        logic        mod_segment;
        logic        thermo;    // Bit 0
    } fpga_state_t;

endpackage

// ==== source/settings_pkg.sv ====
package settings_pkg;

    // Word 0 of the group is the last member, so it sits in the low bits
    typedef struct packed {
        logic [15:0] completion_steps_phase;
        logic [15:0] completion_steps_intensity;
        logic [15:0] update_rate_phase;
        logic [15:0] update_rate_intensity;
        logic [15:0] mode;
    } silencer_settings_t;

    typedef struct packed {
        logic [63:0] ecat_sync_time;    // Word 0 holds bits 15:0
    } sync_settings_t;

    localparam logic [15:0] SILENCER_MODE_FIXED_COMPLETION_STEPS = 16'd0;
    localparam logic [15:0] SILENCER_MODE_FIXED_UPDATE_RATE      = 16'd1;

    localparam silencer_settings_t SILENCER_DEFAULTS = '{
        completion_steps_phase:     16'd40,
        completion_steps_intensity: 16'd10,
        update_rate_phase:          16'd256,
        update_rate_intensity:      16'd256,
        mode:                       SILENCER_MODE_FIXED_COMPLETION_STEPS
    };

    localparam sync_settings_t SYNC_DEFAULTS = '{
        ecat_sync_time: 64'd0
    };

endpackage

// ==== source/read_return_tracker.sv ====
`timescale 1ns/10ps

module read_return_tracker
    import ctl_bus_pkg::*;
#(
    parameter int READ_LATENCY = 2
) (
    input  logic         CLK,
    input  logic         rst_n,
    input  read_return_t tag_req,
    output read_return_t rd_return
);

    logic [READ_LATENCY-1:0] valid_q;
    read_tag_t               tag_q [READ_LATENCY];
    logic [2:0]              idx_q [READ_LATENCY];

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= tag_req.valid;
            for (int i = 1; i < READ_LATENCY; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // Tag and index only mean something while the matching valid bit is set
    always_ff @(posedge CLK) begin
        tag_q[0] <= tag_req.tag;
        idx_q[0] <= tag_req.idx;
        for (int i = 1; i < READ_LATENCY; i++) begin
            tag_q[i] <= tag_q[i-1];
            idx_q[i] <= idx_q[i-1];
        end
    end

    assign rd_return = '{
        valid: valid_q[READ_LATENCY-1],
        tag:   tag_q[READ_LATENCY-1],
        idx:   idx_q[READ_LATENCY-1]
    };

    a_latency_min: assert property (@(posedge CLK) READ_LATENCY >= 1)
        else $error("READ_LATENCY must be at least 1");

endmodule

// ==== source/settings_loader.sv ====
`timescale 1ns/10ps

module settings_loader
    import ctl_bus_pkg::*;
#(
    parameter type       payload_t  = logic [WORD_W-1:0],
    parameter read_tag_t LOADER_TAG = TAG_SILENCER,
    parameter payload_t  DEFAULTS   = '0
) (
    input  logic              CLK,
    input  logic              rst_n,
    input  read_return_t      rd_return,
    input  logic [WORD_W-1:0] mem_rdata,
    output payload_t          settings,
    output logic              update
);

    localparam int WORD_COUNT = $bits(payload_t) / WORD_W;

    logic hit;
    logic last_word;

    assign hit       = rd_return.valid && (rd_return.tag == LOADER_TAG);
    assign last_word = (rd_return.idx == 3'(WORD_COUNT - 1));

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            settings <= DEFAULTS;
            update   <= 1'b0;
        end else begin
            update <= hit && last_word; // Lines up with the last word landing in settings
            if (hit) begin
                settings[rd_return.idx * WORD_W +: WORD_W] <= mem_rdata;
            end
        end
    end

    // The sequencer sizes its burst from the same type, so an index past the end
    // means the two sides disagree on the group
    a_idx_range: assert property (
        @(posedge CLK) disable iff (!rst_n)
        hit |-> (rd_return.idx < WORD_COUNT)
    ) else $error("Read index %0d beyond %0d words", rd_return.idx, WORD_COUNT);

    a_whole_words: assert property (@(posedge CLK) ($bits(payload_t) % WORD_W) == 0)
        else $error("Payload of %0d bits is not a whole number of words", $bits(payload_t));

endmodule

// ==== source/ctl_bus_sequencer.sv ====
`timescale 1ns/10ps

module ctl_bus_sequencer
    import ctl_bus_pkg::*;
    import settings_pkg::*;
#(
    parameter logic [WORD_W-1:0] VERSION_MAJOR = 16'h00a0,
    parameter logic [WORD_W-1:0] VERSION_MINOR = 16'h0003
) (
    input  logic              CLK,
    input  logic              rst_n,
    input  logic              thermo,
    input  logic              stm_segment,
    input  logic              mod_segment,
    input  logic [WORD_W-1:0] stm_cycle,
    input  logic [WORD_W-1:0] mem_rdata,
    input  read_return_t      rd_return,
    output ctl_req_t          mem_req,
    output read_return_t      tag_req,
    output logic              force_fan
);

    localparam int SILENCER_WORDS = $bits(silencer_settings_t) / WORD_W;
    localparam int SYNC_WORDS     = $bits(sync_settings_t) / WORD_W;

    typedef enum logic [3:0] {
        ST_VER_MINOR,
        ST_VER_MAJOR,
        ST_POLL_RD,
        ST_POLL_WR,
        ST_POLL_WAIT,
        ST_DECIDE,
        ST_BURST,
        ST_FLAG_WB,
        ST_STATUS_WB
    } state_t;

    state_t            state;
    logic [WORD_W-1:0] ctl_flags;
    logic              flags_fresh;   // Flag word of the current poll has come back
    read_tag_t         burst_tag;
    logic [ADDR_W-1:0] burst_base;
    logic [2:0]        burst_idx;
    logic [2:0]        burst_last;
    fpga_state_t       status;

    function automatic ctl_req_t rd_req(input logic [ADDR_W-1:0] address);
        rd_req = '{we: 1'b0, addr: address, wdata: '0};
    endfunction

    function automatic ctl_req_t wr_req(input logic [ADDR_W-1:0] address,
                                        input logic [WORD_W-1:0] data);
        wr_req = '{we: 1'b1, addr: address, wdata: data};
    endfunction

    function automatic read_return_t rd_tag(input read_tag_t t, input logic [2:0] i);
        rd_tag = '{valid: 1'b1, tag: t, idx: i};
    endfunction

    assign status = '{
        reserved:       '0,
        stm_cycle_zero: (stm_cycle == '0),
        stm_segment:    stm_segment,
        mod_segment:    mod_segment,
        thermo:         thermo
    };

    assign force_fan = ctl_flags[CTL_FLAG_FORCE_FAN];

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_VER_MINOR;
            mem_req     <= CTL_REQ_IDLE;
            tag_req     <= '0;
            ctl_flags   <= '0;
            flags_fresh <= 1'b0;
            burst_tag   <= TAG_CTL_FLAG;
            burst_base  <= '0;
            burst_idx   <= '0;
            burst_last  <= '0;
        end else begin
            mem_req <= CTL_REQ_IDLE;
            tag_req <= '0;

            if (rd_return.valid && (rd_return.tag == TAG_CTL_FLAG)) begin
                ctl_flags   <= mem_rdata;
                flags_fresh <= 1'b1;
            end

            case (state)
                ST_VER_MINOR: begin
                    mem_req <= wr_req(ADDR_VERSION_MINOR, VERSION_MINOR);
                    state   <= ST_VER_MAJOR;
                end
                ST_VER_MAJOR: begin
                    mem_req <= wr_req(ADDR_VERSION_MAJOR, VERSION_MAJOR);
                    state   <= ST_POLL_RD;
                end
                ST_POLL_RD: begin
                    mem_req     <= rd_req(ADDR_CTL_FLAG);
                    tag_req     <= rd_tag(TAG_CTL_FLAG, 3'd0);
                    flags_fresh <= 1'b0;
                    state       <= ST_POLL_WR;
                end
                ST_POLL_WR: begin
                    mem_req <= wr_req(ADDR_FPGA_STATE, status);
                    state   <= ST_POLL_WAIT;
                end
                ST_POLL_WAIT: begin
                    state <= ST_DECIDE;
                end
                ST_DECIDE: begin
                    // Stays here until the flag word is back, whatever the latency
                    if (flags_fresh) begin
                        burst_idx <= '0;
                        if (ctl_flags[CTL_FLAG_SILENCER_SET]) begin
                            ctl_flags[CTL_FLAG_SILENCER_SET] <= 1'b0;
                            burst_tag  <= TAG_SILENCER;
                            burst_base <= SILENCER_BASE_ADDR;
                            burst_last <= 3'(SILENCER_WORDS - 1);
                            state      <= ST_BURST;
                        end else if (ctl_flags[CTL_FLAG_SYNC_SET]) begin
                            ctl_flags[CTL_FLAG_SYNC_SET] <= 1'b0;
                            burst_tag  <= TAG_SYNC;
                            burst_base <= SYNC_BASE_ADDR;
                            burst_last <= 3'(SYNC_WORDS - 1);
                            state      <= ST_BURST;
                        end else begin
                            mem_req     <= rd_req(ADDR_CTL_FLAG); // Next poll starts at once
                            tag_req     <= rd_tag(TAG_CTL_FLAG, 3'd0);
                            flags_fresh <= 1'b0;
                            state       <= ST_POLL_WR;
                        end
                    end
                end
                ST_BURST: begin
                    mem_req   <= rd_req(burst_base + ADDR_W'(burst_idx));
                    tag_req   <= rd_tag(burst_tag, burst_idx);
                    burst_idx <= burst_idx + 3'd1;
                    if (burst_idx == burst_last) begin
                        state <= ST_FLAG_WB;
                    end
                end
                ST_FLAG_WB: begin
                    mem_req <= wr_req(ADDR_CTL_FLAG, ctl_flags); // Served bit already cleared
                    state   <= ST_STATUS_WB;
                end
                ST_STATUS_WB: begin
                    mem_req <= wr_req(ADDR_FPGA_STATE, status);
                    state   <= ST_POLL_RD;
                end
                default: begin
                    state <= ST_POLL_RD;
                end
            endcase
        end
    end

    // The tracker would pair a write cycle with returning data that never comes
    a_no_tag_on_write: assert property (
        @(posedge CLK) disable iff (!rst_n)
        tag_req.valid |-> !mem_req.we
    ) else $error("Read tag issued together with a write");

endmodule

// ==== source/controller.sv ====
`timescale 1ns/10ps

module controller
    import ctl_bus_pkg::*;
    import settings_pkg::*;
#(
    parameter int                READ_LATENCY  = 2,
    parameter logic [WORD_W-1:0] VERSION_MAJOR = 16'h00a0,
    parameter logic [WORD_W-1:0] VERSION_MINOR = 16'h0003
) (
    input  logic               CLK,
    input  logic               rst_n,
    input  logic               thermo,
    input  logic               stm_segment,
    input  logic               mod_segment,
    input  logic [WORD_W-1:0]  stm_cycle,
    output ctl_req_t           mem_req,
    input  logic [WORD_W-1:0]  mem_rdata,
    output silencer_settings_t silencer_settings,
    output logic               silencer_update,
    output sync_settings_t     sync_settings,
    output logic               sync_update,
    output logic               force_fan
);

    read_return_t tag_req;
    read_return_t rd_return;   // Aligned with mem_rdata

    ctl_bus_sequencer #(
        .VERSION_MAJOR(VERSION_MAJOR),
        .VERSION_MINOR(VERSION_MINOR)
    ) sequencer0 (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .thermo     (thermo),
        .stm_segment(stm_segment),
        .mod_segment(mod_segment),
        .stm_cycle  (stm_cycle),
        .mem_rdata  (mem_rdata),
        .rd_return  (rd_return),
        .mem_req    (mem_req),
        .tag_req    (tag_req),
        .force_fan  (force_fan)
    );

    read_return_tracker #(
        .READ_LATENCY(READ_LATENCY)
    ) tracker0 (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .tag_req  (tag_req),
        .rd_return(rd_return)
    );

    settings_loader #(
        .payload_t (silencer_settings_t),
        .LOADER_TAG(TAG_SILENCER),
        .DEFAULTS  (SILENCER_DEFAULTS)
    ) silencer_loader0 (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .rd_return(rd_return),
        .mem_rdata(mem_rdata),
        .settings (silencer_settings),
        .update   (silencer_update)
    );

    settings_loader #(
        .payload_t (sync_settings_t),
        .LOADER_TAG(TAG_SYNC),
        .DEFAULTS  (SYNC_DEFAULTS)
    ) sync_loader0 (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .rd_return(rd_return),
        .mem_rdata(mem_rdata),
        .settings (sync_settings),
        .update   (sync_update)
    );

endmodule

// ==== sim/reg_memory_model.sv ====
`timescale 1ns/10ps

module reg_memory_model
    import ctl_bus_pkg::*;
#(
    parameter int READ_LATENCY = 2
) (
    input  logic              CLK,
    input  ctl_req_t          req,
    output logic [WORD_W-1:0] rdata,
    input  logic              host_we,
    input  logic [ADDR_W-1:0] host_addr,
    input  logic [WORD_W-1:0] host_wdata
);

    logic [WORD_W-1:0] mem [2**ADDR_W];
    logic [WORD_W-1:0] rd_pipe [READ_LATENCY];

    initial begin
        for (int a = 0; a < 2**ADDR_W; a++) begin
            mem[a] = {~8'(a), 8'(a)};
        end
        mem[ADDR_CTL_FLAG] = '0; // No flags pending at power-up
        for (int i = 0; i < READ_LATENCY; i++) begin
            rd_pipe[i] = '0;
        end
    end

    always @(posedge CLK) begin
        rd_pipe[0] <= mem[req.addr]; // Old contents, a write in this cycle lands afterwards
        for (int i = 1; i < READ_LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
        if (req.we) begin
            mem[req.addr] <= req.wdata;
        end
        if (host_we) begin
            mem[host_addr] <= host_wdata;
        end
    end

    assign rdata = rd_pipe[READ_LATENCY-1];

endmodule

// ==== sim/tb_controller.sv ====
`timescale 1ns/10ps

module tb_controller
    import ctl_bus_pkg::*;
    import settings_pkg::*;
;

    localparam int                READ_LATENCY   = 2;
    localparam logic [WORD_W-1:0] VERSION_MAJOR  = 16'h00a1;
    localparam logic [WORD_W-1:0] VERSION_MINOR  = 16'h0007;
    localparam int                ROUNDS         = 40;
    localparam int                TIMEOUT_CYCLES = ROUNDS * 200;
    localparam int                POLL_CYCLES    = 4;

    logic               CLK = 1'b0;
    logic               rst_n;
    logic               thermo;
    logic               stm_segment;
    logic               mod_segment;
    logic [WORD_W-1:0]  stm_cycle;
    ctl_req_t           mem_req;
    logic [WORD_W-1:0]  mem_rdata;
    silencer_settings_t silencer_settings;
    logic               silencer_update;
    sync_settings_t     sync_settings;
    logic               sync_update;
    logic               force_fan;
    logic               host_we;
    logic [ADDR_W-1:0]  host_addr;
    logic [WORD_W-1:0]  host_wdata;
    logic [31:0]        rng;
    logic               fan_bit;
    int                 cycle_count = 0;

    controller #(
        .READ_LATENCY (READ_LATENCY),
        .VERSION_MAJOR(VERSION_MAJOR),
        .VERSION_MINOR(VERSION_MINOR)
    ) dut0 (
        .CLK              (CLK),
        .rst_n            (rst_n),
        .thermo           (thermo),
        .stm_segment      (stm_segment),
        .mod_segment      (mod_segment),
        .stm_cycle        (stm_cycle),
        .mem_req          (mem_req),
        .mem_rdata        (mem_rdata),
        .silencer_settings(silencer_settings),
        .silencer_update  (silencer_update),
        .sync_settings    (sync_settings),
        .sync_update      (sync_update),
        .force_fan        (force_fan)
    );

    reg_memory_model #(
        .READ_LATENCY(READ_LATENCY)
    ) mem0 (
        .CLK       (CLK),
        .req       (mem_req),
        .rdata     (mem_rdata),
        .host_we   (host_we),
        .host_addr (host_addr),
        .host_wdata(host_wdata)
    );

    always #50 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw(output logic [31:0] value);
        rng   = xorshift32(rng);
        value = rng;
    endtask

    task automatic check_value(input logic [79:0] actual, input logic [79:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("error %0t: %s, got %h, expected %h", $time, what, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
        @(posedge CLK);
        host_we    <= 1'b1;
        host_addr  <= addr;
        host_wdata <= data;
        @(posedge CLK);
        host_we    <= 1'b0;
    endtask

    function automatic logic [WORD_W-1:0] flag_word(input logic sil, input logic syn);
        logic [WORD_W-1:0] w;
        w = '0;
        w[CTL_FLAG_FORCE_FAN]    = fan_bit;
        w[CTL_FLAG_SILENCER_SET] = sil;
        w[CTL_FLAG_SYNC_SET]     = syn;
        return w;
    endfunction

    // Fills the chosen groups, raises their flags and follows the strobes
    task automatic load_groups(input logic do_sil, input logic do_sync);
        logic [79:0] sil_exp;
        logic [63:0] sync_exp;
        logic [31:0] r;
        for (int i = 0; i < 5 && do_sil; i++) begin
            draw(r);
            sil_exp[i*16 +: 16] = r[15:0];
            host_write(SILENCER_BASE_ADDR + 8'(i), r[15:0]);
        end
        for (int i = 0; i < 4 && do_sync; i++) begin
            draw(r);
            sync_exp[i*16 +: 16] = r[31:16];
            host_write(SYNC_BASE_ADDR + 8'(i), r[31:16]);
        end
        host_write(ADDR_CTL_FLAG, flag_word(do_sil, do_sync));
        do @(negedge CLK); while (!silencer_update && !sync_update);
        if (do_sil) begin
            check_value(sync_update, 1'b0, "sync update ahead of silencer update");
            check_value(silencer_settings, sil_exp, "silencer settings");
            @(negedge CLK);
            check_value(silencer_update, 1'b0, "silencer update longer than one cycle");
            while (do_sync && !sync_update) @(negedge CLK);
        end
        if (do_sync) begin
            check_value(silencer_update, 1'b0, "silencer update during sync update");
            check_value(sync_settings, sync_exp, "sync settings");
            @(negedge CLK);
            check_value(sync_update, 1'b0, "sync update longer than one cycle");
        end
        do @(negedge CLK); while (mem0.mem[ADDR_CTL_FLAG] !== flag_word(1'b0, 1'b0));
        check_value(force_fan, fan_bit, "force_fan after load");
    endtask

    task automatic status_round();
        logic [31:0] r;
        logic [15:0] expected;
        draw(r);
        @(posedge CLK);
        thermo      <= r[0];
        mod_segment <= r[1];
        stm_segment <= r[2];
        stm_cycle   <= (r[7:4] == 4'd0) ? 16'd0 : r[31:16]; // Zero now and then
        fan_bit = r[3];
        host_write(ADDR_CTL_FLAG, flag_word(1'b0, 1'b0));
        repeat (3 * POLL_CYCLES + READ_LATENCY) @(negedge CLK);
        expected = {12'd0, stm_cycle == 16'd0, stm_segment, mod_segment, thermo};
        check_value(mem0.mem[ADDR_FPGA_STATE], expected, "status word");
        check_value(force_fan, fan_bit, "force_fan");
    endtask

    initial begin
        rst_n       = 1'b0;
        thermo      = 1'b0;
        stm_segment = 1'b0;
        mod_segment = 1'b0;
        stm_cycle   = '0;
        host_we     = 1'b0;
        host_addr   = '0;
        host_wdata  = '0;
        fan_bit     = 1'b0;
        rng         = 32'h9f55_423a;
        repeat (5) @(posedge CLK);
        rst_n <= 1'b1;
        @(negedge CLK);
        check_value(mem_req.we, 1'b0, "write enable before the first version write");
        repeat (3) @(negedge CLK); // Both version writes go out in the first two cycles
        check_value(mem0.mem[ADDR_VERSION_MINOR], VERSION_MINOR, "version minor");
        check_value(mem0.mem[ADDR_VERSION_MAJOR], VERSION_MAJOR, "version major");
        check_value({silencer_update, sync_update, force_fan}, 3'b000, "strobes after reset");
        // Word 4 down to word 0, fixed completion steps mode in word 0
        check_value(silencer_settings, {16'd40, 16'd10, 16'd256, 16'd256, 16'd0},
                    "silencer defaults");
        check_value(sync_settings, 64'd0, "sync defaults");
        for (int round = 0; round < ROUNDS; round++) begin
            case (round % 4)
                0: load_groups(1'b1, 1'b0);
                1: load_groups(1'b0, 1'b1);
                2: load_groups(1'b1, 1'b1);
                default: status_round();
            endcase
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== tb.f ====
source/ctl_bus_pkg.sv
source/settings_pkg.sv
source/read_return_tracker.sv
source/settings_loader.sv
source/ctl_bus_sequencer.sv
source/controller.sv
sim/reg_memory_model.sv
sim/tb_controller.sv

// ==== Bender.yml ====
package:
  name: ctl_poller

sources:
  - source/ctl_bus_pkg.sv
  - source/settings_pkg.sv
  - source/read_return_tracker.sv
  - source/settings_loader.sv
  - source/ctl_bus_sequencer.sv
  - source/controller.sv
  - target: simulation
    files:
      - sim/reg_memory_model.sv
      - sim/tb_controller.sv
